/* rtl/rms_norm_cfg.svh */
/* Vector geometry and fixed-point formats for the RMS-norm datapath.
   Included by the package and by every module that sizes a register. */
`ifndef RMS_NORM_CFG_SVH
`define RMS_NORM_CFG_SVH

// 2x2 lanes per beat
`define RMS_LANES        4
// 4x4 tensor with 2 channels arrives in 8 beats
`define RMS_ITERS        8
`define RMS_NUM_VALUES   32

// Signed input samples
`define RMS_IN_WIDTH     8
`define RMS_IN_FRAC      2

// Squares and their running sum keep twice the input fraction bits
`define RMS_SQ_WIDTH     16
`define RMS_ACC_WIDTH    21

// Unsigned inverse square root
`define RMS_SCALE_WIDTH  16
`define RMS_SCALE_FRAC   12

// Signed normalised output
`define RMS_OUT_WIDTH    8
`define RMS_OUT_FRAC     4

// Room for two whole vectors
`define RMS_FIFO_DEPTH   16

`endif

/* rtl/rms_norm_pkg.sv */
/* Tile, sum and scale types shared by the RMS-norm RTL and its testbench.
   Widths come from the config header. */
`default_nettype none

`include "rms_norm_cfg.svh"

package rms_norm_pkg;

    // Named signed lanes so that element selects stay signed
    typedef logic signed [`RMS_IN_WIDTH-1:0] in_lane_t;
    typedef logic signed [`RMS_OUT_WIDTH-1:0] out_lane_t;

    typedef struct packed {
        in_lane_t [`RMS_LANES-1:0] lanes;
    } tile_in_t;

    typedef struct packed {
        out_lane_t [`RMS_LANES-1:0] lanes;
    } tile_out_t;

    // Sum of the squared lanes of one beat
    typedef logic [`RMS_SQ_WIDTH+$clog2(`RMS_LANES)-1:0] sum_t;

    // Mean square, 4 fraction bits
    typedef logic [`RMS_ACC_WIDTH-1:0] mean_sq_t;

    // Inverse square root of the mean square
    typedef logic [`RMS_SCALE_WIDTH-1:0] scale_t;

endpackage

`default_nettype wire

/* rtl/skid_buffer.sv */
/* Two-entry valid/ready register slice with a registered ready.
   Gives full throughput on any payload type. */
`timescale 1ns/1ps
`default_nettype none

module skid_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t out_q;
    payload_t skid_q;
    logic     out_valid_q, out_valid_d;
    logic     skid_valid_q, skid_valid_d;
    logic     ready_q;
    logic     in_fire, out_load;

    assign in_fire   = in_valid && ready_q;
    // Main register is free or drains this cycle
    assign out_load  = !out_valid_q || out_ready;

    assign in_ready  = ready_q;
    assign out_valid = out_valid_q;
    assign out_data  = out_q;

    always_comb begin
        out_valid_d  = out_valid_q;
        skid_valid_d = skid_valid_q;
        if (out_load) begin
            out_valid_d  = skid_valid_q || in_fire;
            skid_valid_d = 1'b0;
        end else if (in_fire) begin
            skid_valid_d = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
            ready_q      <= 1'b0;
        end else begin
            out_valid_q  <= out_valid_d;
            skid_valid_q <= skid_valid_d;
            ready_q      <= !skid_valid_d;
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            out_q <= skid_valid_q ? skid_q : in_data;
        end
        // Catch the beat that arrived while the output was stalled
        if (in_fire && !out_load) begin
            skid_q <= in_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/matrix_fifo.sv */
/* Circular tile FIFO that holds each vector's inputs until its scale is known.
   Ready is registered and drops while the buffer is full. */
`timescale 1ns/1ps
`default_nettype none

`include "rms_norm_cfg.svh"

module matrix_fifo (
    input  logic                   clk,
    input  logic                   reset,
    input  rms_norm_pkg::tile_in_t in_data,
    input  logic                   in_valid,
    output logic                   in_ready,
    output rms_norm_pkg::tile_in_t out_data,
    output logic                   out_valid,
    input  logic                   out_ready
);

    localparam int DEPTH = `RMS_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    rms_norm_pkg::tile_in_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q, count_d;
    logic             ready_q;
    logic             wr_en, rd_en;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign wr_en     = in_valid && ready_q;
    assign rd_en     = out_valid && out_ready;
    assign count_d   = count_q + CNT_W'(wr_en) - CNT_W'(rd_en);

    assign in_ready  = ready_q;
    assign out_valid = count_q != '0;
    assign out_data  = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            ready_q  <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (rd_en) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            count_q <= count_d;
            ready_q <= count_d != CNT_W'(DEPTH);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= in_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/sum_squares.sv */
/* Squares each lane, reduces the tile and accumulates one vector.
   Offers the mean square two cycles after the last beat is accepted. */
`timescale 1ns/1ps
`default_nettype none

`include "rms_norm_cfg.svh"

module sum_squares (
    input  logic                   clk,
    input  logic                   reset,
    input  rms_norm_pkg::tile_in_t in_data,
    input  logic                   in_valid,
    output logic                   in_ready,
    output rms_norm_pkg::mean_sq_t out_data,
    output logic                   out_valid,
    input  logic                   out_ready
);

    localparam int LANES       = `RMS_LANES;
    localparam int ITER_W      = $clog2(`RMS_ITERS);
    localparam int INV_SHIFT   = 16;
    localparam logic [INV_SHIFT:0] INV_N = (1 << INV_SHIFT) / `RMS_NUM_VALUES;
    localparam int MEAN_PROD_W = `RMS_ACC_WIDTH + INV_SHIFT + 1;

    logic [`RMS_SQ_WIDTH-1:0]  sq_d [LANES];
    logic [`RMS_SQ_WIDTH-1:0]  sq_q [LANES];
    logic                      sq_valid_q;
    rms_norm_pkg::sum_t        pair_sum [LANES/2];
    rms_norm_pkg::sum_t        tree_sum, sum_data;
    logic                      sum_in_ready, sum_valid, sum_ready;
    logic [`RMS_ACC_WIDTH-1:0] acc_q, acc_total;
    logic [MEAN_PROD_W-1:0]    mean_prod;
    logic [ITER_W-1:0]         beat_q;
    logic                      out_valid_q, sum_fire, last_beat;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            sq_d[i] = $signed(in_data.lanes[i]) * $signed(in_data.lanes[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sq_valid_q <= 1'b0;
        end else if (in_ready) begin
            sq_valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            sq_q <= sq_d;
        end
    end

    // Pairwise adds, then the pair sums
    always_comb begin
        tree_sum = '0;
        for (int j = 0; j < LANES/2; j++) begin
            pair_sum[j] = rms_norm_pkg::sum_t'(sq_q[2*j]) + sq_q[2*j+1];
            tree_sum    = tree_sum + pair_sum[j];
        end
    end

    assign in_ready = !sq_valid_q || sum_in_ready;

    skid_buffer #(
        .payload_t (rms_norm_pkg::sum_t)
    ) sum_skid (
        .clk       (clk),
        .reset     (reset),
        .in_data   (tree_sum),
        .in_valid  (sq_valid_q),
        .in_ready  (sum_in_ready),
        .out_data  (sum_data),
        .out_valid (sum_valid),
        .out_ready (sum_ready)
    );

    // Whole path stalls while a mean waits downstream
    assign sum_ready = !out_valid_q || out_ready;
    assign sum_fire  = sum_valid && sum_ready;
    assign last_beat = beat_q == ITER_W'(`RMS_ITERS - 1);
    assign acc_total = acc_q + sum_data;
    assign mean_prod = acc_total * INV_N;
    assign out_valid = out_valid_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_q      <= '0;
            acc_q       <= '0;
            out_valid_q <= 1'b0;
        end else begin
            if (out_valid_q && out_ready) begin
                out_valid_q <= 1'b0;
            end
            if (sum_fire) begin
                if (last_beat) begin
                    beat_q      <= '0;
                    acc_q       <= '0;
                    out_valid_q <= 1'b1;
                end else begin
                    beat_q <= beat_q + 1'b1;
                    acc_q  <= acc_total;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sum_fire && last_beat) begin
            out_data <= mean_prod[INV_SHIFT +: `RMS_ACC_WIDTH];
        end
    end

endmodule

`default_nettype wire

/* rtl/fixed_isqrt.sv */
/* Bit-serial inverse square root, one result bit per cycle from the top.
   Output is valid 17 cycles after an input is taken and held until accepted. */
`timescale 1ns/1ps
`default_nettype none

`include "rms_norm_cfg.svh"

module fixed_isqrt (
    input  logic                   clk,
    input  logic                   reset,
    input  rms_norm_pkg::mean_sq_t in_data,
    input  logic                   in_valid,
    output logic                   in_ready,
    output rms_norm_pkg::scale_t   out_data,
    output logic                   out_valid,
    input  logic                   out_ready
);

    localparam int W      = `RMS_SCALE_WIDTH;
    localparam int PROD_W = 2 * `RMS_SCALE_WIDTH + `RMS_ACC_WIDTH;
    // r*r*m equal to one in the combined fixed-point format
    localparam logic [PROD_W-1:0] LIMIT =
        PROD_W'(1) << (2 * `RMS_SCALE_FRAC + 2 * `RMS_IN_FRAC);

    rms_norm_pkg::mean_sq_t m_q;
    rms_norm_pkg::scale_t   r_q, bit_q, trial;
    logic [PROD_W-1:0]      trial_sq_m;
    logic                   busy_q, out_valid_q, in_fire;

    assign in_fire    = in_valid && in_ready;
    assign trial      = r_q | bit_q;
    assign trial_sq_m = trial * trial * m_q;

    assign in_ready   = !busy_q && !out_valid_q;
    assign out_valid  = out_valid_q;
    assign out_data   = r_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q      <= 1'b0;
            out_valid_q <= 1'b0;
            bit_q       <= '0;
        end else begin
            if (in_fire) begin
                busy_q <= 1'b1;
                bit_q  <= {1'b1, {(W-1){1'b0}}};
            end else if (busy_q) begin
                bit_q <= bit_q >> 1;
                // All bits decided, spend one more cycle to publish
                if (bit_q == '0) begin
                    busy_q      <= 1'b0;
                    out_valid_q <= 1'b1;
                end
            end else if (out_valid_q && out_ready) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    // Zero mean keeps every trial bit and saturates to all ones
    always_ff @(posedge clk) begin
        if (in_fire) begin
            m_q <= in_data;
            r_q <= '0;
        end else if (busy_q && trial_sq_m <= LIMIT) begin
            r_q <= trial;
        end
    end

endmodule

`default_nettype wire

/* rtl/norm_scale.sv */
/* Joins buffered tiles with their vector's scale and multiplies each lane.
   Floors and saturates into the output format, releasing the scale after 8 beats. */
`timescale 1ns/1ps
`default_nettype none

`include "rms_norm_cfg.svh"

module norm_scale (
    input  logic                    clk,
    input  logic                    reset,
    input  rms_norm_pkg::scale_t    scale,
    input  logic                    scale_valid,
    output logic                    scale_ready,
    input  rms_norm_pkg::tile_in_t  in_data,
    input  logic                    in_valid,
    output logic                    in_ready,
    output rms_norm_pkg::tile_out_t out_data,
    output logic                    out_valid,
    input  logic                    out_ready
);

    localparam int PROD_W = `RMS_IN_WIDTH + `RMS_SCALE_WIDTH + 1;
    localparam int SHIFT  = `RMS_IN_FRAC + `RMS_SCALE_FRAC - `RMS_OUT_FRAC;
    localparam int ITER_W = $clog2(`RMS_ITERS);
    localparam logic signed [PROD_W-1:0] OUT_MAX = 2 ** (`RMS_OUT_WIDTH - 1) - 1;
    localparam logic signed [PROD_W-1:0] OUT_MIN = -(2 ** (`RMS_OUT_WIDTH - 1));

    rms_norm_pkg::tile_out_t  norm_d;
    logic signed [PROD_W-1:0] prod [`RMS_LANES];
    logic signed [PROD_W-1:0] floored [`RMS_LANES];
    logic [ITER_W-1:0]        beat_q;
    logic                     join_valid, join_ready, fire, last_beat;

    assign join_valid  = scale_valid && in_valid;
    assign fire        = join_valid && join_ready;
    assign last_beat   = beat_q == ITER_W'(`RMS_ITERS - 1);
    assign in_ready    = scale_valid && join_ready;
    assign scale_ready = in_valid && join_ready && last_beat;

    always_comb begin
        for (int i = 0; i < `RMS_LANES; i++) begin
            prod[i]    = $signed({1'b0, scale}) * $signed(in_data.lanes[i]);
            // Arithmetic shift rounds toward minus infinity
            floored[i] = prod[i] >>> SHIFT;
            if (floored[i] > OUT_MAX) begin
                norm_d.lanes[i] = OUT_MAX[`RMS_OUT_WIDTH-1:0];
            end else if (floored[i] < OUT_MIN) begin
                norm_d.lanes[i] = OUT_MIN[`RMS_OUT_WIDTH-1:0];
            end else begin
                norm_d.lanes[i] = floored[i][`RMS_OUT_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_q <= '0;
        end else if (fire) begin
            beat_q <= last_beat ? '0 : beat_q + 1'b1;
        end
    end

    skid_buffer #(
        .payload_t (rms_norm_pkg::tile_out_t)
    ) out_skid (
        .clk       (clk),
        .reset     (reset),
        .in_data   (norm_d),
        .in_valid  (join_valid),
        .in_ready  (join_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

/* rtl/rms_norm_2d.sv */
/* Streaming RMS-norm over one 4x4x2 vector in 8 tile beats.
   Inputs wait in a FIFO while the scale path computes 1/rms for their vector. */
`timescale 1ns/1ps
`default_nettype none

module rms_norm_2d (
    input  logic                    clk,
    input  logic                    reset,
    input  rms_norm_pkg::tile_in_t  in_data,
    input  logic                    in_valid,
    output logic                    in_ready,
    output rms_norm_pkg::tile_out_t out_data,
    output logic                    out_valid,
    input  logic                    out_ready
);

    logic                   fifo_in_valid, fifo_in_ready;
    rms_norm_pkg::tile_in_t fifo_data;
    logic                   fifo_out_valid, fifo_out_ready;

    logic                   sq_in_valid, sq_in_ready;
    rms_norm_pkg::mean_sq_t mean_data;
    logic                   mean_valid, mean_ready;

    rms_norm_pkg::scale_t   scale_data;
    logic                   scale_valid, scale_ready;

    // Each branch sees valid only when the other can take the same beat
    assign fifo_in_valid = in_valid && sq_in_ready;
    assign sq_in_valid   = in_valid && fifo_in_ready;
    assign in_ready      = fifo_in_ready && sq_in_ready;

    matrix_fifo input_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_data   (in_data),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .out_data  (fifo_data),
        .out_valid (fifo_out_valid),
        .out_ready (fifo_out_ready)
    );

    sum_squares mean_square (
        .clk       (clk),
        .reset     (reset),
        .in_data   (in_data),
        .in_valid  (sq_in_valid),
        .in_ready  (sq_in_ready),
        .out_data  (mean_data),
        .out_valid (mean_valid),
        .out_ready (mean_ready)
    );

    fixed_isqrt inv_sqrt (
        .clk       (clk),
        .reset     (reset),
        .in_data   (mean_data),
        .in_valid  (mean_valid),
        .in_ready  (mean_ready),
        .out_data  (scale_data),
        .out_valid (scale_valid),
        .out_ready (scale_ready)
    );

    norm_scale normalise (
        .clk         (clk),
        .reset       (reset),
        .scale       (scale_data),
        .scale_valid (scale_valid),
        .scale_ready (scale_ready),
        .in_data     (fifo_data),
        .in_valid    (fifo_out_valid),
        .in_ready    (fifo_out_ready),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

`default_nettype wire

/* sim/clock_gen.sv */
/* Free-running testbench clock and a reset held for the first edges.
   Reset falls 1 ns after an edge so no sampling edge sees it move. */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

/* sim/rms_norm_checker.sv */
/* Handshake assertions for the RMS-norm top level.
   Attached to every rms_norm_2d instance by the bind at the end. */
`timescale 1ns/1ps
`default_nettype none

module rms_norm_checker (
    input logic                    clk,
    input logic                    reset,
    input logic                    in_ready,
    input rms_norm_pkg::tile_out_t out_data,
    input logic                    out_valid,
    input logic                    out_ready
);

    // Output valid is registered, so it is clear one edge into reset
    reset_clears_valid: assert property (
        @(posedge clk) reset |=> !out_valid
    ) else $error("out_valid is high while reset is applied");

    output_holds_under_stall: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("output beat changed or dropped while out_ready was low");

    handshake_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(in_ready) && !$isunknown(out_valid)
    ) else $error("in_ready or out_valid is unknown after reset");

endmodule

bind rms_norm_2d rms_norm_checker handshake_checks (
    .clk       (clk),
    .reset     (reset),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

`default_nettype wire

/* sim/rms_norm_tb.sv */
/* Testbench for the RMS-norm top level, driven by the cases file.
   Run from the project root so that the cases file path resolves. */
`timescale 1ns/1ps
`default_nettype none

`include "rms_norm_cfg.svh"

module rms_norm_tb;

    localparam int    NUM_CASES  = 8;
    localparam int    ITERS      = `RMS_ITERS;
    // Mode word, then input tiles, then expected tiles
    localparam int    WORDS      = 1 + 2 * ITERS;
    localparam int    MAX_CYCLES = NUM_CASES * 200 + 20;
    localparam string CASES_FILE = "sim/rms_norm_cases.txt";

    logic                    clk;
    logic                    reset;
    rms_norm_pkg::tile_in_t  in_data;
    logic                    in_valid;
    logic                    in_ready;
    rms_norm_pkg::tile_out_t out_data;
    logic                    out_valid;
    logic                    out_ready;

    logic [31:0] case_mem [NUM_CASES * WORDS];
    logic [31:0] lcg_state;
    int          beats_seen;
    int          cycles;

    clock_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (2)
    ) clocks (
        .clk   (clk),
        .reset (reset)
    );

    rms_norm_2d uut (
        .clk       (clk),
        .reset     (reset),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Bit 0 random out_ready, bit 1 wait for earlier outputs first
    function automatic logic [31:0] mode_of(input int vec);
        return case_mem[vec * WORDS];
    endfunction

    task automatic compare_tile(input rms_norm_pkg::tile_out_t got,
                                input rms_norm_pkg::tile_out_t expected,
                                input int vec, input int beat);
        if (got !== expected) begin
            $display("Mismatch at time %0t: vector %0d beat %0d gave %h, expected %h",
                     $time, vec, beat, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "output tile differs from the expected tile");
        end
    endtask

    task automatic drive_vectors();
        logic        accepted;
        logic [31:0] mode_word;
        for (int v = 0; v < NUM_CASES; v++) begin
            mode_word = mode_of(v);
            if (mode_word[1]) begin
                in_valid = 1'b0;
                while (beats_seen < v * ITERS) begin
                    @(posedge clk);
                    #1;
                end
            end
            for (int b = 0; b < ITERS; b++) begin
                in_data  = case_mem[v * WORDS + 1 + b];
                in_valid = 1'b1;
                accepted = 1'b0;
                while (!accepted) begin
                    @(negedge clk);
                    accepted = in_ready;
                    @(posedge clk);
                    #1;
                end
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic monitor_outputs();
        int          vec;
        int          beat;
        logic [31:0] mode_word;
        while (beats_seen < NUM_CASES * ITERS) begin
            vec       = beats_seen / ITERS;
            beat      = beats_seen % ITERS;
            mode_word = mode_of(vec);
            lcg_state = lcg_next(lcg_state);
            out_ready = mode_word[0] ? lcg_state[16] : 1'b1;
            @(negedge clk);
            if (out_valid && out_ready) begin
                compare_tile(out_data, case_mem[vec * WORDS + 1 + ITERS + beat], vec, beat);
                beats_seen++;
            end
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: outputs still missing after %0d cycles", MAX_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "simulation ran past its cycle limit");
    end

    initial begin
        int   file_id;
        logic extra_beat;
        in_data    = '0;
        in_valid   = 1'b0;
        out_ready  = 1'b0;
        beats_seen = 0;
        lcg_state  = 32'h9946_3aa8;
        file_id = $fopen(CASES_FILE, "r");
        if (file_id == 0) begin
            $display("Cannot open the cases file %s", CASES_FILE);
            $display("STATUS: FAIL");
            $fatal(1, "stimulus file missing");
        end
        $fclose(file_id);
        $readmemh(CASES_FILE, case_mem);

        @(posedge clk);
        while (reset) begin
            @(posedge clk);
        end
        #1;
        fork
            drive_vectors();
            monitor_outputs();
        join

        // Nothing may come out once every vector is done
        out_ready  = 1'b1;
        extra_beat = 1'b0;
        repeat (20) begin
            @(negedge clk);
            if (out_valid) begin
                extra_beat = 1'b1;
            end
        end
        if (extra_beat) begin
            $display("An output beat appeared after the last expected vector");
            $display("STATUS: FAIL");
            $fatal(1, "unexpected output beat");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sim/rms_norm_cases.txt */
// Line 1: mode (bit 0 random out_ready, bit 1 wait for earlier outputs), 8 input tiles
// Line 2: 8 expected output tiles; lane 3 is the top byte of each tile
00000002 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101
10101010 10101010 10101010 10101010 10101010 10101010 10101010 10101010
00000002 03FB07FE F80CFF06 03FB07FE F80CFF06 03FB07FE F80CFF06 03FB07FE F80CFF06
07F311FB EC1DFD0E 07F311FB EC1DFD0E 07F311FB EC1DFD0E 07F311FB EC1DFD0E
00000002 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000002 00000000 00000000 00000000 00050000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 007F0000 00000000 00000000 00000000 00000000
00000002 00000000 00000000 00000000 00000000 00000000 00000000 0000FB00 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00008000 00000000
00000001 03FB07FE F80CFF06 03FB07FE F80CFF06 03FB07FE F80CFF06 03FB07FE F80CFF06
07F311FB EC1DFD0E 07F311FB EC1DFD0E 07F311FB EC1DFD0E 07F311FB EC1DFD0E
00000001 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101
10101010 10101010 10101010 10101010 10101010 10101010 10101010 10101010
00000000 03FB07FE F80CFF06 03FB07FE F80CFF06 03FB07FE F80CFF06 03FB07FE F80CFF06
07F311FB EC1DFD0E 07F311FB EC1DFD0E 07F311FB EC1DFD0E 07F311FB EC1DFD0E

/* all.f */
+incdir+rtl
rtl/rms_norm_pkg.sv
rtl/skid_buffer.sv
rtl/matrix_fifo.sv
rtl/sum_squares.sv
rtl/fixed_isqrt.sv
rtl/norm_scale.sv
rtl/rms_norm_2d.sv
sim/clock_gen.sv
sim/rms_norm_checker.sv
sim/rms_norm_tb.sv

/* run.sh */
#!/bin/sh
# Builds the RMS-norm testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module rms_norm_tb -o rms_norm_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/rms_norm_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1
